/* common/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////

// addresses count words, not bytes
`define CACHE_ADDR_W   16
`define CACHE_DATA_W   32

// one word per line, so index and tag split the whole address
`define CACHE_INDEX_W  4
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_INDEX_W)

`define CACHE_LINES    (1 << `CACHE_INDEX_W)  // 16 lines

`endif

/* common/cache_pkg.sv */
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  typedef logic [`CACHE_DATA_W-1:0]  word_t;
  typedef logic [`CACHE_INDEX_W-1:0] index_t;
  typedef logic [`CACHE_TAG_W-1:0]   tag_t;

  // tag in the upper bits, index in the lower
  typedef struct packed {
    tag_t   tag;
    index_t index;
  } addr_fields_s;

  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] flat;
    addr_fields_s             fields;
  } cache_addr_u;

  typedef struct packed {
    logic        write;  // 1 for write, 0 for read
    cache_addr_u addr;
    word_t       wdata;
  } cpu_req_s;

  // write-back of a dirty victim
  typedef struct packed {
    cache_addr_u addr;
    word_t       data;
  } mem_wr_s;

  typedef enum logic [2:0] {
    IDLE,
    TAG_CHECK,
    WRITE_UPDATE,
    RESPOND,
    EVICT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE
  } ctrl_state_e;

endpackage

`default_nettype wire

/* cache/line_status.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module line_status (
  input  logic              clk,
  input  logic              rst_n,
  input  cache_pkg::index_t index,
  input  logic              valid_we,
  input  logic              valid_wd,
  input  logic              dirty_we,
  input  logic              dirty_wd,
  output logic              line_valid,
  output logic              line_dirty
);

  // one bit per line
  logic [`CACHE_LINES-1:0] valid_q;
  logic [`CACHE_LINES-1:0] dirty_q;

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;  // all lines invalid
      dirty_q <= '0;
    end else begin
      if (valid_we) begin
        valid_q[index] <= valid_wd;
      end
      if (dirty_we) begin
        dirty_q[index] <= dirty_wd;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////
  assign line_valid = valid_q[index];
  assign line_dirty = dirty_q[index];

endmodule

`default_nettype wire

/* cache/line_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module line_store (
  input  logic              clk,
  input  cache_pkg::index_t index,
  input  logic              store_we,
  input  logic              data_we,
  input  logic              fill_sel,
  input  cache_pkg::tag_t   wr_tag,
  input  cache_pkg::word_t  fill_data,  // refill word from memory
  input  cache_pkg::word_t  wr_data,    // client write word
  output cache_pkg::tag_t   line_tag,
  output cache_pkg::word_t  line_data
);
  import cache_pkg::*;

  tag_t  tag_mem  [0:`CACHE_LINES-1];
  word_t data_mem [0:`CACHE_LINES-1];

  word_t data_wd;
  logic  data_wen;

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////
  assign data_wd  = fill_sel ? fill_data : wr_data;
  assign data_wen = store_we || data_we;  // refill or client write

  always_ff @(posedge clk) begin
    if (store_we) begin
      tag_mem[index] <= wr_tag;
    end
    if (data_wen) begin
      data_mem[index] <= data_wd;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////
  // combinational, so the tag check sees the line in the same cycle
  assign line_tag  = tag_mem[index];
  assign line_data = data_mem[index];

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  // client side
  input  logic                   cpu_req_valid,
  input  cache_pkg::cpu_req_s    cpu_req,
  output logic                   cpu_req_ready,
  output logic                   cpu_resp_valid,
  output cache_pkg::word_t       cpu_resp_data,
  input  logic                   cpu_resp_ready,
  // memory side
  output logic                   mem_rd_req_valid,
  output cache_pkg::cache_addr_u mem_rd_addr,
  input  logic                   mem_rd_req_ready,
  input  logic                   mem_rd_resp_valid,
  output logic                   mem_rd_resp_ready,
  output logic                   mem_wr_valid,
  output cache_pkg::mem_wr_s     mem_wr,
  input  logic                   mem_wr_ready,
  // valid and dirty bits
  input  logic                   line_valid,
  input  logic                   line_dirty,
  output cache_pkg::index_t      index,
  output logic                   valid_we,
  output logic                   valid_wd,
  output logic                   dirty_we,
  output logic                   dirty_wd,
  // tag and data arrays
  input  cache_pkg::tag_t        line_tag,
  input  cache_pkg::word_t       line_data,
  output logic                   store_we,
  output logic                   data_we,
  output logic                   fill_sel,
  output cache_pkg::word_t       wr_data
);
  import cache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  cpu_req_s    req_q;    // request held until its response
  logic        tag_hit;

  ////////////////////////////////////////////////////////////
  // state and request registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_req_valid && cpu_req_ready) begin
      req_q <= cpu_req;
    end
  end

  assign index   = req_q.addr.fields.index;  // arrays always look at the held request
  assign tag_hit = line_valid && (line_tag == req_q.addr.fields.tag);

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cpu_req_valid) state_d = TAG_CHECK;
      end
      TAG_CHECK: begin
        if (tag_hit) begin
          state_d = req_q.write ? WRITE_UPDATE : RESPOND;
        end else if (line_valid && line_dirty) begin
          state_d = EVICT;  // victim goes out first
        end else begin
          state_d = REFILL_REQ;
        end
      end
      WRITE_UPDATE: state_d = RESPOND;
      RESPOND: begin
        if (cpu_resp_ready) state_d = IDLE;
      end
      EVICT: begin
        if (mem_wr_ready) state_d = REFILL_REQ;
      end
      REFILL_REQ: begin
        if (mem_rd_req_ready) state_d = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        if (mem_rd_resp_valid) state_d = REFILL_UPDATE;
      end
      REFILL_UPDATE: state_d = req_q.write ? WRITE_UPDATE : RESPOND;
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // control outputs
  ////////////////////////////////////////////////////////////
  always_comb begin
    cpu_req_ready     = 1'b0;
    cpu_resp_valid    = 1'b0;
    mem_rd_req_valid  = 1'b0;
    mem_rd_resp_ready = 1'b0;
    mem_wr_valid      = 1'b0;
    valid_we          = 1'b0;
    valid_wd          = 1'b0;
    dirty_we          = 1'b0;
    dirty_wd          = 1'b0;
    store_we          = 1'b0;
    data_we           = 1'b0;
    fill_sel          = 1'b0;
    case (state_q)
      IDLE:         cpu_req_ready = 1'b1;
      WRITE_UPDATE: begin
        data_we  = 1'b1;  // client word into data array
        dirty_we = 1'b1;
        dirty_wd = 1'b1;
      end
      RESPOND:      cpu_resp_valid = 1'b1;
      EVICT:        mem_wr_valid = 1'b1;
      REFILL_REQ: begin
        mem_rd_req_valid = 1'b1;
        valid_we         = 1'b1;  // line invalid while it is refilled
      end
      REFILL_WAIT: begin
        mem_rd_resp_ready = 1'b1;
        fill_sel          = 1'b1;
        store_we          = mem_rd_resp_valid;  // capture on the handshake
      end
      REFILL_UPDATE: begin
        valid_we = 1'b1;
        valid_wd = 1'b1;
        dirty_we = 1'b1;  // fresh line is clean
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // payloads
  ////////////////////////////////////////////////////////////
  always_comb begin
    mem_wr.addr.fields.tag   = line_tag;  // victim address from stored tag
    mem_wr.addr.fields.index = req_q.addr.fields.index;
    mem_wr.data              = line_data;
  end

  assign mem_rd_addr   = req_q.addr;
  assign cpu_resp_data = line_data;
  assign wr_data       = req_q.wdata;

endmodule

`default_nettype wire

/* src/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // client
  input  logic                   cpu_req_valid,
  input  cache_pkg::cpu_req_s    cpu_req,
  output logic                   cpu_req_ready,
  output logic                   cpu_resp_valid,
  output cache_pkg::word_t       cpu_resp_data,
  input  logic                   cpu_resp_ready,
  // memory
  output logic                   mem_rd_req_valid,
  output cache_pkg::cache_addr_u mem_rd_addr,
  input  logic                   mem_rd_req_ready,
  input  logic                   mem_rd_resp_valid,
  input  cache_pkg::word_t       mem_rd_data,
  output logic                   mem_rd_resp_ready,
  output logic                   mem_wr_valid,
  output cache_pkg::mem_wr_s     mem_wr,
  input  logic                   mem_wr_ready
);
  import cache_pkg::*;

  index_t index;
  logic   line_valid;
  logic   line_dirty;
  logic   valid_we;
  logic   valid_wd;
  logic   dirty_we;
  logic   dirty_wd;
  tag_t   line_tag;
  word_t  line_data;
  logic   store_we;
  logic   data_we;
  logic   fill_sel;
  word_t  wr_data;

  cache_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .cpu_req_valid    (cpu_req_valid),
    .cpu_req          (cpu_req),
    .cpu_req_ready    (cpu_req_ready),
    .cpu_resp_valid   (cpu_resp_valid),
    .cpu_resp_data    (cpu_resp_data),
    .cpu_resp_ready   (cpu_resp_ready),
    .mem_rd_req_valid (mem_rd_req_valid),
    .mem_rd_addr      (mem_rd_addr),
    .mem_rd_req_ready (mem_rd_req_ready),
    .mem_rd_resp_valid(mem_rd_resp_valid),
    .mem_rd_resp_ready(mem_rd_resp_ready),
    .mem_wr_valid     (mem_wr_valid),
    .mem_wr           (mem_wr),
    .mem_wr_ready     (mem_wr_ready),
    .line_valid       (line_valid),
    .line_dirty       (line_dirty),
    .index            (index),
    .valid_we         (valid_we),
    .valid_wd         (valid_wd),
    .dirty_we         (dirty_we),
    .dirty_wd         (dirty_wd),
    .line_tag         (line_tag),
    .line_data        (line_data),
    .store_we         (store_we),
    .data_we          (data_we),
    .fill_sel         (fill_sel),
    .wr_data          (wr_data)
  );

  line_status u_status (
    .clk       (clk),
    .rst_n     (rst_n),
    .index     (index),
    .valid_we  (valid_we),
    .valid_wd  (valid_wd),
    .dirty_we  (dirty_we),
    .dirty_wd  (dirty_wd),
    .line_valid(line_valid),
    .line_dirty(line_dirty)
  );

  // refill tag is the tag of the address being fetched
  line_store u_store (
    .clk      (clk),
    .index    (index),
    .store_we (store_we),
    .data_we  (data_we),
    .fill_sel (fill_sel),
    .wr_tag   (mem_rd_addr.fields.tag),
    .fill_data(mem_rd_data),
    .wr_data  (wr_data),
    .line_tag (line_tag),
    .line_data(line_data)
  );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;  // 40 ns period
    end
  end

endmodule

`default_nettype wire

/* verif/tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module tb_cache;
  import cache_pkg::*;

  localparam int N_STEPS = 12;

  // client request per row with the expected part filled by predict
  typedef struct packed {
    logic        write;
    cache_addr_u addr;
    word_t       wdata;
    logic [2:0]  stall;  // cycles with cpu_resp_ready low
    word_t       exp_data;
    logic        exp_wb;
    cache_addr_u wb_addr;
    word_t       wb_data;
    logic        exp_refill;
  } step_s;

  logic        clk;
  logic        rst_n;
  logic        cpu_req_valid;
  cpu_req_s    cpu_req;
  logic        cpu_req_ready;
  logic        cpu_resp_valid;
  word_t       cpu_resp_data;
  logic        cpu_resp_ready;
  logic        mem_rd_req_valid;
  cache_addr_u mem_rd_addr;
  logic        mem_rd_req_ready;
  logic        mem_rd_resp_valid;
  word_t       mem_rd_data;
  logic        mem_rd_resp_ready;
  logic        mem_wr_valid;
  mem_wr_s     mem_wr;
  logic        mem_wr_ready;

  step_s  steps     [N_STEPS];
  word_t  mem       [0:(1 << `CACHE_ADDR_W)-1];
  word_t  ref_mem   [0:(1 << `CACHE_ADDR_W)-1];
  tag_t   ref_tag   [`CACHE_LINES];
  word_t  ref_data  [`CACHE_LINES];
  logic   ref_valid [`CACHE_LINES];
  logic   ref_dirty [`CACHE_LINES];
  integer seed = 66;

  logic        rd_pending;  // memory model bookkeeping
  cache_addr_u rd_addr;
  int          rd_count;
  int          rd_wb_mark;  // write-backs already done when the last read was taken
  int          wb_count;
  mem_wr_s     wb_last;

  logic    wr_wait;  // valid held while ready low
  logic    resp_wait;
  mem_wr_s wr_hold;
  word_t   resp_hold;

  clk_gen u_clk (.clk(clk));

  cache_top uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .cpu_req_valid    (cpu_req_valid),
    .cpu_req          (cpu_req),
    .cpu_req_ready    (cpu_req_ready),
    .cpu_resp_valid   (cpu_resp_valid),
    .cpu_resp_data    (cpu_resp_data),
    .cpu_resp_ready   (cpu_resp_ready),
    .mem_rd_req_valid (mem_rd_req_valid),
    .mem_rd_addr      (mem_rd_addr),
    .mem_rd_req_ready (mem_rd_req_ready),
    .mem_rd_resp_valid(mem_rd_resp_valid),
    .mem_rd_data      (mem_rd_data),
    .mem_rd_resp_ready(mem_rd_resp_ready),
    .mem_wr_valid     (mem_wr_valid),
    .mem_wr           (mem_wr),
    .mem_wr_ready     (mem_wr_ready)
  );

  ////////////////////////////////////////////////////////////
  // reporting and compare tasks
  ////////////////////////////////////////////////////////////
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input cache_addr_u got,
                            input cache_addr_u exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %h expected %h",
                         $time, name, got.flat, exp.flat));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // table and reference model
  ////////////////////////////////////////////////////////////
  function automatic word_t fill_word(input logic [`CACHE_ADDR_W-1:0] a);
    return {a ^ 16'h5a3c, ~a};  // differs for every address
  endfunction

  function automatic step_s make_step(input logic write, input logic [`CACHE_ADDR_W-1:0] addr,
                                      input word_t wdata, input int stall);
    step_s s;
    s           = '0;
    s.write     = write;
    s.addr.flat = addr;
    s.wdata     = wdata;
    s.stall     = stall[2:0];
    return s;
  endfunction

  task automatic init_memories();
    int a;
    for (a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
      mem[a]     = fill_word(a[`CACHE_ADDR_W-1:0]);
      ref_mem[a] = fill_word(a[`CACHE_ADDR_W-1:0]);
    end
    for (a = 0; a < `CACHE_LINES; a++) begin
      ref_tag[a]   = '0;
      ref_data[a]  = '0;
      ref_valid[a] = 1'b0;  // cold cache
      ref_dirty[a] = 1'b0;
    end
  endtask

  task automatic load_table();
    steps[0]  = make_step(1'b0, 16'h0123, 32'h0, 0);  // cold read miss
    steps[1]  = make_step(1'b0, 16'h0123, 32'h0, 0);  // read hit
    steps[2]  = make_step(1'b1, 16'h0123, 32'hdeadbeef, 2);  // write hit
    steps[3]  = make_step(1'b0, 16'h0123, 32'h0, 0);
    steps[4]  = make_step(1'b0, 16'h0453, 32'h0, 1);  // dirty conflict at index 3
    steps[5]  = make_step(1'b0, 16'h0123, 32'h0, 0);  // clean conflict reads written-back word
    steps[6]  = make_step(1'b1, 16'h0785, 32'h12345678, 0);  // write miss
    steps[7]  = make_step(1'b0, 16'h0785, 32'h0, 3);
    steps[8]  = make_step(1'b1, 16'h0995, 32'hcafef00d, 1);  // dirty write miss
    steps[9]  = make_step(1'b0, 16'h0785, 32'h0, 2);
    steps[10] = make_step(1'b1, 16'h0fff, 32'h0badc0de, 4);
    steps[11] = make_step(1'b0, 16'h0fff, 32'h0, 0);
  endtask

  // walks the cache rules ahead of the run
  task automatic predict(inout step_s s);
    index_t i;
    logic   hit;
    i   = s.addr.fields.index;
    hit = ref_valid[i] && (ref_tag[i] == s.addr.fields.tag);
    s.exp_wb               = !hit && ref_valid[i] && ref_dirty[i];
    s.wb_addr.fields.tag   = ref_tag[i];
    s.wb_addr.fields.index = i;
    s.wb_data              = ref_data[i];
    s.exp_refill           = !hit;
    if (s.exp_wb) begin
      ref_mem[s.wb_addr.flat] = ref_data[i];
    end
    if (!hit) begin
      ref_tag[i]   = s.addr.fields.tag;
      ref_data[i]  = ref_mem[s.addr.flat];
      ref_valid[i] = 1'b1;
      ref_dirty[i] = 1'b0;
    end
    if (s.write) begin
      ref_data[i]  = s.wdata;
      ref_dirty[i] = 1'b1;
    end
    s.exp_data = ref_data[i];
  endtask

  ////////////////////////////////////////////////////////////
  // memory model with random ready and response delay
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_rd_req_ready  <= 1'b0;
      mem_rd_resp_valid <= 1'b0;
      mem_wr_ready      <= 1'b0;
      rd_pending        <= 1'b0;
    end else begin
      mem_wr_ready     <= ($random(seed) & 3) != 0;
      mem_rd_req_ready <= ($random(seed) & 3) != 0;
      if (mem_wr_valid && mem_wr_ready) begin
        mem[mem_wr.addr.flat] = mem_wr.data;
        wb_count <= wb_count + 1;
        wb_last  <= mem_wr;
      end
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        rd_pending <= 1'b1;
        rd_addr    <= mem_rd_addr;
        rd_count   <= rd_count + 1;
        rd_wb_mark <= wb_count;
      end
      if (mem_rd_resp_valid && mem_rd_resp_ready) begin
        mem_rd_resp_valid <= 1'b0;
        rd_pending        <= 1'b0;
      end else if (rd_pending && !mem_rd_resp_valid && ($random(seed) & 1)) begin
        mem_rd_resp_valid <= 1'b1;
        mem_rd_data       <= mem[rd_addr.flat];
      end
    end
  end

  // payload must not move while valid waits for ready
  always @(posedge clk) begin
    if (wr_wait) begin
      check_flag("mem_wr_valid", mem_wr_valid, 1'b1);
      check_addr("mem_wr.addr", mem_wr.addr, wr_hold.addr);
      check_word("mem_wr.data", mem_wr.data, wr_hold.data);
    end
    if (resp_wait) begin
      check_flag("cpu_resp_valid", cpu_resp_valid, 1'b1);
      check_word("cpu_resp_data", cpu_resp_data, resp_hold);
    end
    wr_wait   <= rst_n && mem_wr_valid && !mem_wr_ready;
    wr_hold   <= mem_wr;
    resp_wait <= rst_n && cpu_resp_valid && !cpu_resp_ready;
    resp_hold <= cpu_resp_data;
  end

  ////////////////////////////////////////////////////////////
  // one request through the DUT
  ////////////////////////////////////////////////////////////
  task automatic run_step(input step_s s);
    int lat;
    int rd0;
    int wb0;
    cpu_req_valid <= 1'b1;
    cpu_req       <= '{write: s.write, addr: s.addr, wdata: s.wdata};
    do @(posedge clk); while (!cpu_req_ready);  // accepting edge
    cpu_req_valid <= 1'b0;
    rd0 = rd_count;
    wb0 = wb_count;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!cpu_resp_valid);
    if (!s.exp_refill) begin
      check_word("cpu_resp_valid delay", word_t'(lat), s.write ? 32'd3 : 32'd2);
    end
    repeat (s.stall) @(posedge clk);
    cpu_resp_ready <= 1'b1;
    @(posedge clk);  // response transfer
    cpu_resp_ready <= 1'b0;
    check_word("cpu_resp_data", cpu_resp_data, s.exp_data);
    check_word("mem read count", word_t'(rd_count - rd0), word_t'(s.exp_refill));
    check_word("mem write-back count", word_t'(wb_count - wb0), word_t'(s.exp_wb));
    if (s.exp_refill) begin
      check_addr("mem_rd_addr", rd_addr, s.addr);
    end
    if (s.exp_wb) begin
      check_addr("mem_wr.addr", wb_last.addr, s.wb_addr);
      check_word("mem_wr.data", wb_last.data, s.wb_data);
      check_word("write-backs before mem read", word_t'(rd_wb_mark - wb0), 32'd1);
    end
  endtask

  initial begin
    #(N_STEPS * 40 * 40);
    fail_now("timeout: the request table did not complete in time");
  end

  initial begin
    int n;
    rst_n             <= 1'b0;
    cpu_req_valid     <= 1'b0;
    cpu_req           <= '0;
    cpu_resp_ready    <= 1'b0;
    mem_rd_req_ready  <= 1'b0;
    mem_rd_resp_valid <= 1'b0;
    mem_rd_data       <= '0;
    mem_wr_ready      <= 1'b0;
    init_memories();
    load_table();
    for (n = 0; n < N_STEPS; n++) begin
      predict(steps[n]);
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_flag("cpu_req_ready", cpu_req_ready, 1'b1);
    check_flag("cpu_resp_valid", cpu_resp_valid, 1'b0);
    check_flag("mem_rd_req_valid", mem_rd_req_valid, 1'b0);
    check_flag("mem_rd_resp_ready", mem_rd_resp_ready, 1'b0);
    check_flag("mem_wr_valid", mem_wr_valid, 1'b0);

    for (n = 0; n < N_STEPS; n++) begin
      run_step(steps[n]);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/cache_pkg.sv
cache/line_status.sv
cache/line_store.sv
cache/cache_ctrl.sv
src/cache_top.sv
verif/clk_gen.sv
verif/tb_cache.sv
